// File: hw/ssm_cfg.svh
/*
 * build-time sizes for the SSM step pipeline
 * data width, fraction bits, state length, head and channel counts
 */

`ifndef SSM_CFG_SVH
`define SSM_CFG_SVH

// ==========================================================================
// number format
// ==========================================================================

// signed Q4.12 word
`define SSM_DW      16

// products are shifted right by this many bits
`define SSM_FRAC    12

// ==========================================================================
// problem shape
// ==========================================================================

// state vector length, the N of the scan
`define SSM_N       4

// per-head dt, dA and D entries in the parameter table
`define SSM_HEADS   4

// channels per head, only sizes the channel tag
`define SSM_CHANS   8

`endif

// File: hw/ssm_pkg.sv
/*
 * shared types for the SSM step pipeline
 * fixed-point word, state vector, config bundle, per-stage payloads
 */

`include "ssm_cfg.svh"

package ssm_pkg;

    typedef logic signed [`SSM_DW-1:0] fix_t;
    typedef fix_t [`SSM_N-1:0] state_vec_t;
    typedef logic [$clog2(`SSM_HEADS)-1:0] head_t;
    typedef logic [$clog2(`SSM_CHANS)-1:0] chan_t;

    // config index must address both a head and a state element
    localparam int CFG_IDX_W = ($clog2(`SSM_HEADS) > $clog2(`SSM_N)) ?
                               $clog2(`SSM_HEADS) : $clog2(`SSM_N);

    // ======================================================================
    // config port
    // ======================================================================

    typedef enum logic [1:0] {
        CFG_HEAD = 2'd0,
        CFG_B    = 2'd1,
        CFG_C    = 2'd2
    } cfg_op_t;

    // CFG_HEAD: val0 = dt, val1 = dA, val2 = D; B and C use val0 only
    typedef struct packed {
        cfg_op_t               op;
        logic [CFG_IDX_W-1:0]  idx;
        fix_t                  val0;
        fix_t                  val1;
        fix_t                  val2;
    } cfg_wr_t;

    // ======================================================================
    // stage payloads, in pipeline order
    // ======================================================================

    typedef struct packed {
        head_t      head;
        chan_t      chan;
        fix_t       x;
        state_vec_t h_prev;
    } ssm_in_t;

    typedef struct packed {
        ssm_in_t    item;
        fix_t       dt;
        fix_t       da;
        fix_t       d;
        state_vec_t b;
        state_vec_t c;
    } ssm_fetched_t;

    typedef struct packed {
        head_t      head;
        chan_t      chan;
        fix_t       x;
        fix_t       d;
        fix_t       da;
        state_vec_t h_prev;
        state_vec_t c;
        state_vec_t dbx;
    } ssm_dbx_t;

    typedef struct packed {
        head_t      head;
        chan_t      chan;
        fix_t       x;
        fix_t       d;
        state_vec_t c;
        state_vec_t h_next;
    } ssm_upd_t;

    typedef struct packed {
        head_t      head;
        chan_t      chan;
        fix_t       x;
        fix_t       d;
        fix_t       y_tmp;
        state_vec_t h_next;
    } ssm_red_t;

    typedef struct packed {
        head_t      head;
        chan_t      chan;
        fix_t       y;
        state_vec_t h_next;
    } ssm_out_t;

    // full-width product, arithmetic shift by the fraction, keep the low word
    function automatic fix_t fix_mul(input fix_t a, input fix_t b);
        logic signed [2*`SSM_DW-1:0] prod;
        logic signed [2*`SSM_DW-1:0] shifted;
        prod    = a * b;
        shifted = prod >>> `SSM_FRAC;
        return shifted[`SSM_DW-1:0];
    endfunction

endpackage

// File: hw/ssm_param_fetch.sv
/*
 * parameter table with config write port
 * first pipeline stage, attaches head parameters and B, C to each item
 */

`timescale 1ns/1ps
`include "ssm_cfg.svh"

module ssm_param_fetch import ssm_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         cfg_valid,
    input  cfg_wr_t      cfg,
    input  logic         in_valid,
    output logic         in_ready,
    input  ssm_in_t      in_data,
    output logic         out_valid,
    input  logic         out_ready,
    output ssm_fetched_t out_data
);

    // per-head scalars
    fix_t dt_tab [`SSM_HEADS];
    fix_t da_tab [`SSM_HEADS];
    fix_t d_tab  [`SSM_HEADS];

    // shared across heads
    state_vec_t b_vec;
    state_vec_t c_vec;

    // ======================================================================
    // config writes
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `SSM_HEADS; i++) begin
                dt_tab[i] <= '0;
                da_tab[i] <= '0;
                d_tab[i]  <= '0;
            end
            b_vec <= '0;
            c_vec <= '0;
        end else if (cfg_valid) begin
            case (cfg.op)
                CFG_HEAD: begin
                    dt_tab[cfg.idx] <= cfg.val0;
                    da_tab[cfg.idx] <= cfg.val1;
                    d_tab[cfg.idx]  <= cfg.val2;
                end
                CFG_B:   b_vec[cfg.idx] <= cfg.val0;
                CFG_C:   c_vec[cfg.idx] <= cfg.val0;
                default: ;
            endcase
        end
    end

    // ======================================================================
    // fetch stage
    // ======================================================================

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // item keeps the parameters it saw here, later writes do not reach it
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data.item <= in_data;
            out_data.dt   <= dt_tab[in_data.head];
            out_data.da   <= da_tab[in_data.head];
            out_data.d    <= d_tab[in_data.head];
            out_data.b    <= b_vec;
            out_data.c    <= c_vec;
        end
    end

endmodule

// File: hw/ssm_dbx_stage.sv
/*
 * input projection stage: dtx = dt*x, then dbx[n] = dtx*B[n]
 */

`timescale 1ns/1ps
`include "ssm_cfg.svh"

module ssm_dbx_stage import ssm_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    output logic         in_ready,
    input  ssm_fetched_t in_data,
    output logic         out_valid,
    input  logic         out_ready,
    output ssm_dbx_t     out_data
);

    fix_t       dtx;
    state_vec_t dbx;
    ssm_dbx_t   next_data;

    // ======================================================================
    // datapath
    // ======================================================================

    // two multiplies back to back, the longest path in the pipe
    always_comb begin
        dtx = fix_mul(in_data.dt, in_data.item.x);
        for (int n = 0; n < `SSM_N; n++) begin
            dbx[n] = fix_mul(dtx, in_data.b[n]);
        end
    end

    // forward only what the later stages read
    always_comb begin
        next_data.head   = in_data.item.head;
        next_data.chan   = in_data.item.chan;
        next_data.x      = in_data.item.x;
        next_data.d      = in_data.d;
        next_data.da     = in_data.da;
        next_data.h_prev = in_data.item.h_prev;
        next_data.c      = in_data.c;
        next_data.dbx    = dbx;
    end

    // ======================================================================
    // output register
    // ======================================================================

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= next_data;
        end
    end

endmodule

// File: hw/ssm_state_update.sv
/*
 * state update stage: h_next[n] = h_prev[n]*dA + dbx[n]
 */

`timescale 1ns/1ps
`include "ssm_cfg.svh"

module ssm_state_update import ssm_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  ssm_dbx_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output ssm_upd_t out_data
);

    state_vec_t h_next;
    ssm_upd_t   next_data;

    // ======================================================================
    // datapath
    // ======================================================================

    // all N lanes in parallel, the sum wraps at the word width
    always_comb begin
        for (int n = 0; n < `SSM_N; n++) begin
            h_next[n] = fix_mul(in_data.h_prev[n], in_data.da) + in_data.dbx[n];
        end
    end

    always_comb begin
        next_data.head   = in_data.head;
        next_data.chan   = in_data.chan;
        next_data.x      = in_data.x;
        next_data.d      = in_data.d;
        next_data.c      = in_data.c;
        next_data.h_next = h_next;
    end

    // ======================================================================
    // output register
    // ======================================================================

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= next_data;
        end
    end

endmodule

// File: hw/ssm_output_reduce.sv
/*
 * output reduction stage: y_tmp = sum over n of h_next[n]*C[n]
 */

`timescale 1ns/1ps
`include "ssm_cfg.svh"

module ssm_output_reduce import ssm_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  ssm_upd_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output ssm_red_t out_data
);

    // heap layout: leaves at N-1 .. 2N-2, root at 0
    fix_t     tree [2*`SSM_N-1];
    ssm_red_t next_data;

    // ======================================================================
    // products and adder tree
    // ======================================================================

    always_comb begin
        for (int n = 0; n < `SSM_N; n++) begin
            tree[`SSM_N-1+n] = fix_mul(in_data.h_next[n], in_data.c[n]);
        end
        // node i sums children 2i+1 and 2i+2, balanced for power-of-two N
        for (int i = `SSM_N-2; i >= 0; i--) begin
            tree[i] = tree[2*i+1] + tree[2*i+2];
        end
    end

    always_comb begin
        next_data.head   = in_data.head;
        next_data.chan   = in_data.chan;
        next_data.x      = in_data.x;
        next_data.d      = in_data.d;
        next_data.y_tmp  = tree[0];
        next_data.h_next = in_data.h_next;
    end

    // ======================================================================
    // output register
    // ======================================================================

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= next_data;
        end
    end

endmodule

// File: hw/ssm_residual_add.sv
/*
 * final stage: y = y_tmp + D*x, result presented to the caller
 */

`timescale 1ns/1ps
`include "ssm_cfg.svh"

module ssm_residual_add import ssm_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  ssm_red_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output ssm_out_t out_data
);

    fix_t     skip;
    ssm_out_t next_data;

    // ======================================================================
    // skip term
    // ======================================================================

    assign skip = fix_mul(in_data.d, in_data.x);

    // x and D end here
    always_comb begin
        next_data.head   = in_data.head;
        next_data.chan   = in_data.chan;
        next_data.y      = in_data.y_tmp + skip;
        next_data.h_next = in_data.h_next;
    end

    // ======================================================================
    // output register
    // ======================================================================

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= next_data;
        end
    end

endmodule

// File: hw/ssm_step_top.sv
/*
 * SSM recurrent step, five-stage valid/ready pipeline
 */

`timescale 1ns/1ps
`include "ssm_cfg.svh"

module ssm_step_top import ssm_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cfg_valid,
    input  cfg_wr_t  cfg,
    input  logic     in_valid,
    output logic     in_ready,
    input  ssm_in_t  in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output ssm_out_t out_data
);

    // inter-stage links
    logic         fet_valid, fet_ready;
    ssm_fetched_t fet_data;
    logic         dbx_valid, dbx_ready;
    ssm_dbx_t     dbx_data;
    logic         upd_valid, upd_ready;
    ssm_upd_t     upd_data;
    logic         red_valid, red_ready;
    ssm_red_t     red_data;

    ssm_param_fetch u_param_fetch (
        .clk(clk), .rst(rst), .cfg_valid(cfg_valid), .cfg(cfg),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .out_valid(fet_valid), .out_ready(fet_ready), .out_data(fet_data)
    );

    ssm_dbx_stage u_dbx_stage (
        .clk(clk), .rst(rst),
        .in_valid(fet_valid), .in_ready(fet_ready), .in_data(fet_data),
        .out_valid(dbx_valid), .out_ready(dbx_ready), .out_data(dbx_data)
    );

    ssm_state_update u_state_update (
        .clk(clk), .rst(rst),
        .in_valid(dbx_valid), .in_ready(dbx_ready), .in_data(dbx_data),
        .out_valid(upd_valid), .out_ready(upd_ready), .out_data(upd_data)
    );

    ssm_output_reduce u_output_reduce (
        .clk(clk), .rst(rst),
        .in_valid(upd_valid), .in_ready(upd_ready), .in_data(upd_data),
        .out_valid(red_valid), .out_ready(red_ready), .out_data(red_data)
    );

    ssm_residual_add u_residual_add (
        .clk(clk), .rst(rst),
        .in_valid(red_valid), .in_ready(red_ready), .in_data(red_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
    );

endmodule

// File: bench/ssm_step_tb.sv
/*
 * testbench for the SSM step pipeline
 * stimulus table with a Q4.12 reference model, back-pressure and a watchdog
 */

`timescale 1ns/1ps
`include "ssm_cfg.svh"

module ssm_step_tb import ssm_pkg::*; ();

    localparam int MAX_TESTS = 8;
    localparam int MAX_CFGS  = 32;
    localparam int MAX_ITEMS = 64;

    logic     clk;
    logic     rst;
    logic     cfg_valid;
    cfg_wr_t  cfg;
    logic     in_valid;
    logic     in_ready;
    ssm_in_t  in_data;
    logic     out_valid;
    logic     out_ready;
    ssm_out_t out_data;

    // one row per test pointing into the config and item tables
    string t_name    [MAX_TESTS];
    bit    t_bp      [MAX_TESTS];
    int    t_cfg_lo  [MAX_TESTS];
    int    t_cfg_n   [MAX_TESTS];
    int    t_item_lo [MAX_TESTS];
    int    t_item_n  [MAX_TESTS];
    int    n_tests = 0;
    int    n_cfgs  = 0;
    int    n_items = 0;

    cfg_wr_t    cfg_tab   [MAX_CFGS];
    ssm_in_t    item_tab  [MAX_ITEMS];
    int         item_test [MAX_ITEMS];
    fix_t       exp_y     [MAX_ITEMS];
    state_vec_t exp_h     [MAX_ITEMS];

    // reference copy of the parameter table
    fix_t       m_dt [`SSM_HEADS];
    fix_t       m_da [`SSM_HEADS];
    fix_t       m_d  [`SSM_HEADS];
    state_vec_t m_b;
    state_vec_t m_c;

    // items in flight and the cycle of their input transfer
    int pend_idx [$];
    int pend_cyc [$];

    int cycle        = 0;
    int err_count    = 0;
    bit bp_mode      = 1'b0;
    bit tables_ready = 1'b0;

    ssm_step_top u_ssm_step_top (
        .clk(clk), .rst(rst), .cfg_valid(cfg_valid), .cfg(cfg),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ==========================================================================
    // reference model
    // ==========================================================================

    // full product, shift right by 12, keep 16 bits
    function automatic fix_t mul_q412(input fix_t a, input fix_t b);
        int p;
        p = int'(a) * int'(b);
        return p[27:12];
    endfunction

    function automatic state_vec_t vec4(input int a, input int b, input int c, input int d);
        state_vec_t v;
        v[0] = fix_t'(a);
        v[1] = fix_t'(b);
        v[2] = fix_t'(c);
        v[3] = fix_t'(d);
        return v;
    endfunction

    task automatic model_step(input ssm_in_t it, output fix_t y, output state_vec_t h);
        fix_t dtx;
        fix_t acc;
        dtx = mul_q412(m_dt[it.head], it.x);
        acc = '0;
        for (int n = 0; n < `SSM_N; n++) begin
            h[n] = mul_q412(it.h_prev[n], m_da[it.head]) + mul_q412(dtx, m_b[n]);
            acc  = acc + mul_q412(h[n], m_c[n]);
        end
        y = acc + mul_q412(m_d[it.head], it.x);
    endtask

    // ==========================================================================
    // table construction
    // ==========================================================================

    task automatic open_test(input string name, input bit bp);
        t_name[n_tests]    = name;
        t_bp[n_tests]      = bp;
        t_cfg_lo[n_tests]  = n_cfgs;
        t_cfg_n[n_tests]   = 0;
        t_item_lo[n_tests] = n_items;
        t_item_n[n_tests]  = 0;
        n_tests++;
    endtask

    task automatic add_cfg(input cfg_op_t op, input int idx, input int v0,
                           input int v1, input int v2);
        cfg_wr_t w;
        w.op   = op;
        w.idx  = CFG_IDX_W'(idx);
        w.val0 = fix_t'(v0);
        w.val1 = fix_t'(v1);
        w.val2 = fix_t'(v2);
        cfg_tab[n_cfgs] = w;
        n_cfgs++;
        t_cfg_n[n_tests-1]++;
        // items after this write see the new values
        case (op)
            CFG_HEAD: begin
                m_dt[idx] = w.val0;
                m_da[idx] = w.val1;
                m_d[idx]  = w.val2;
            end
            CFG_B:   m_b[idx] = w.val0;
            CFG_C:   m_c[idx] = w.val0;
            default: ;
        endcase
    endtask

    task automatic add_item(input int head, input int chan, input int x, input state_vec_t hp);
        ssm_in_t it;
        it.head   = head_t'(head);
        it.chan   = chan_t'(chan);
        it.x      = fix_t'(x);
        it.h_prev = hp;
        item_tab[n_items]  = it;
        item_test[n_items] = n_tests - 1;
        model_step(it, exp_y[n_items], exp_h[n_items]);
        n_items++;
        t_item_n[n_tests-1]++;
    endtask

    task automatic build_tables();
        for (int h = 0; h < `SSM_HEADS; h++) begin
            m_dt[h] = '0;
            m_da[h] = '0;
            m_d[h]  = '0;
        end
        m_b = '0;
        m_c = '0;

        // tables still empty
        open_test("reset_defaults", 1'b0);
        add_item(1, 3, 'h1800, vec4('h1000, -'h0800, 'h0400, 'h2000));

        // last item has dt*x = 3.5 and B[3] = 4.0, so dbx wraps
        open_test("single_item_math", 1'b0);
        add_cfg(CFG_HEAD, 0, 'h0800, 'h0e00, 'h1000);
        add_cfg(CFG_B, 0, 'h1000, 0, 0);
        add_cfg(CFG_B, 1, -'h2000, 0, 0);
        add_cfg(CFG_B, 2, 'h0c00, 0, 0);
        add_cfg(CFG_B, 3, 'h4000, 0, 0);
        add_cfg(CFG_C, 0, 'h2000, 0, 0);
        add_cfg(CFG_C, 1, 'h1000, 0, 0);
        add_cfg(CFG_C, 2, -'h1800, 0, 0);
        add_cfg(CFG_C, 3, 'h7000, 0, 0);
        add_item(0, 0, 'h1000, vec4('h0400, 'h0800, -'h0c00, 'h1000));
        add_item(0, 5, -'h1400, vec4(-'h2000, 'h1800, 'h0200, -'h0600));
        add_item(0, 7, 'h7000, vec4('h6000, -'h7000, 'h5000, 'h7fff));

        open_test("per_head_params", 1'b0);
        for (int h = 0; h < `SSM_HEADS; h++) begin
            add_cfg(CFG_HEAD, h, 'h0400 * (h + 1), 'h1000 - 'h0300 * h, -'h0800 + 'h0700 * h);
        end
        for (int h = 0; h < `SSM_HEADS; h++) begin
            add_item(h, 7 - h, 'h0c00 - 'h0500 * h, vec4('h0800, -'h0400 * h, 'h0300, 'h1000));
        end

        open_test("streaming_burst", 1'b0);
        for (int i = 0; i < 16; i++) begin
            add_item(i % 4, i % 8, i * 1237 - 9000,
                     vec4(i * 523 - 4000, 3000 - i * 311, i * 97, -i * 401));
        end

        open_test("back_pressure", 1'b1);
        for (int i = 0; i < 20; i++) begin
            add_item((i * 3) % 4, (i * 5) % 8, 7000 - i * 733,
                     vec4(i * 211, -2500 + i * 277, 1200 - i * 150, i * 613 - 6000));
        end

        // new B and C written with the pipe empty
        open_test("reconfig", 1'b0);
        for (int n = 0; n < `SSM_N; n++) begin
            add_cfg(CFG_B, n, 'h0600 - 'h0400 * n, 0, 0);
            add_cfg(CFG_C, n, -'h0c00 + 'h0900 * n, 0, 0);
        end
        for (int i = 0; i < 4; i++) begin
            add_item(i, i + 2, 'h1400 - 'h0a00 * i, vec4('h0200 * i, 'h1000, -'h0800, 'h0600));
        end
        tables_ready = 1'b1;
    endtask

    // ==========================================================================
    // output side
    // ==========================================================================

    task automatic check_output(input int k, input int lat);
        string name;
        name = t_name[item_test[k]];
        if (out_data.y !== exp_y[k]) begin
            $display("CHECK FAILED %s item %0d y: expected %h, actual %h",
                     name, k, exp_y[k], out_data.y);
            err_count++;
        end
        if (out_data.h_next !== exp_h[k]) begin
            $display("CHECK FAILED %s item %0d h_next: expected %h, actual %h",
                     name, k, exp_h[k], out_data.h_next);
            err_count++;
        end
        if (out_data.head !== item_tab[k].head || out_data.chan !== item_tab[k].chan) begin
            $display("CHECK FAILED %s item %0d head/chan: expected %0d/%0d, actual %0d/%0d",
                     name, k, item_tab[k].head, item_tab[k].chan,
                     out_data.head, out_data.chan);
            err_count++;
        end
        // fixed latency only holds with out_ready high throughout
        if (!t_bp[item_test[k]] && lat != 5) begin
            $display("CHECK FAILED %s item %0d latency: expected 5, actual %0d",
                     name, k, lat);
            err_count++;
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int          k;
        int          c0;
        rnd = $urandom(32'h6118);
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (out_valid && pend_idx.size() == 0) begin
                $display("output presented with no item in flight, chan %0d", out_data.chan);
                err_count++;
            end else if (out_valid && out_ready) begin
                k  = pend_idx.pop_front();
                c0 = pend_cyc.pop_front();
                check_output(k, cycle - c0);
            end
            #1;
            if (bp_mode) begin
                rnd = $urandom;
                out_ready = (rnd[1:0] != 2'b00);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // ==========================================================================
    // input side and test sequence
    // ==========================================================================

    initial begin
        int k;
        int errs_at_start;
        int tests_ok;
        int tests_bad;
        tests_ok  = 0;
        tests_bad = 0;
        rst       = 1'b1;
        cfg_valid = 1'b0;
        cfg       = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        build_tables();
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        if (out_valid !== 1'b0) begin
            $display("out_valid is high right after reset");
            err_count++;
        end

        for (int t = 0; t < n_tests; t++) begin
            errs_at_start = err_count;
            bp_mode = t_bp[t];
            for (int j = 0; j < t_cfg_n[t]; j++) begin
                cfg_valid = 1'b1;
                cfg = cfg_tab[t_cfg_lo[t] + j];
                @(posedge clk);
                #1;
            end
            cfg_valid = 1'b0;
            for (int j = 0; j < t_item_n[t]; j++) begin
                k = t_item_lo[t] + j;
                in_valid = 1'b1;
                in_data  = item_tab[k];
                @(posedge clk);
                // one item per cycle when nothing pushes back
                if (!t_bp[t] && !in_ready) begin
                    $display("in_ready low in test %s item %0d with out_ready held high",
                             t_name[t], k);
                    err_count++;
                end
                while (!in_ready) @(posedge clk);
                pend_idx.push_back(k);
                pend_cyc.push_back(cycle);
                #1;
            end
            in_valid = 1'b0;
            // drain before the next test touches the config port
            while (pend_idx.size() != 0) @(posedge clk);
            #1;
            if (err_count == errs_at_start) begin
                tests_ok++;
                $display("test %s ok, %0d items", t_name[t], t_item_n[t]);
            end else begin
                tests_bad++;
                $display("test %s failed, %0d errors", t_name[t], err_count - errs_at_start);
            end
        end

        $display("tests ok: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog sized from the item count
    initial begin
        int limit;
        wait (tables_ready);
        limit = n_items * 20 + 200;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, %0d expected outputs never arrived",
                 limit, pend_idx.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: src.f
+incdir+hw
hw/ssm_pkg.sv
hw/ssm_param_fetch.sv
hw/ssm_dbx_stage.sv
hw/ssm_state_update.sv
hw/ssm_output_reduce.sv
hw/ssm_residual_add.sv
hw/ssm_step_top.sv
bench/ssm_step_tb.sv

// File: run.sh
#!/bin/sh
# build the SSM step testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module ssm_step_tb -o ssm_step_sim

out=$(./obj_dir/ssm_step_sim)
echo "$out"

# exit status follows the search for the pass line
echo "$out" | grep -qF "*** TEST PASSED ***"
